// ==== files.f ====
hdl/systolic_pkg.sv
hdl/matmul_sequencer.sv
hdl/operand_feeder.sv
hdl/mac_pe.sv
hdl/pe_array.sv
hdl/result_drain.sv
hdl/matmul_4x4_systolic.sv
test/matmul_sva.sv
test/tb_matmul.sv

// ==== hdl/mac_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_pe
(
    input  logic                clk,
    input  logic                clear,
    input  systolic_pkg::elem_t in_a,
    input  systolic_pkg::elem_t in_b,
    output systolic_pkg::elem_t out_a,
    output systolic_pkg::elem_t out_b,
    output systolic_pkg::elem_t acc
);

    import systolic_pkg::*;

    elem_t prod_q;
    elem_t acc_q;

    ////////////////////////////////////////////////////////////
    // Forwarding and multiply-accumulate
    ////////////////////////////////////////////////////////////

    // The forwarding registers double as the first MAC stage
    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            out_a  <= '0;
            out_b  <= '0;
            prod_q <= '0;
            acc_q  <= '0;
        end
        else
        begin
            out_a  <= in_a;
            out_b  <= in_b;
            // Product and sum both keep the low byte only
            prod_q <= out_a * out_b;
            acc_q  <= acc_q + prod_q;
        end
    end

    assign acc = acc_q;

endmodule

`default_nettype wire

// ==== hdl/matmul_4x4_systolic.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_4x4_systolic
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  systolic_pkg::addr_t        addr_a,
    input  systolic_pkg::addr_t        addr_b,
    input  systolic_pkg::addr_t        addr_c,
    input  systolic_pkg::stride_t      stride_a,
    input  systolic_pkg::stride_t      stride_b,
    input  systolic_pkg::stride_t      stride_c,
    output systolic_pkg::addr_t        a_addr,
    output systolic_pkg::addr_t        b_addr,
    input  systolic_pkg::operand_vec_t a_data,
    input  systolic_pkg::operand_vec_t b_data,
    output systolic_pkg::c_write_t     c_out,
    output logic                       done
);

    import systolic_pkg::*;

    cnt_t         cnt;
    logic         latch;
    logic         array_clear;
    operand_vec_t a_edge;
    operand_vec_t b_edge;
    result_mat_t  results;

    matmul_sequencer u_sequencer
    (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .cnt         (cnt),
        .latch       (latch),
        .array_clear (array_clear),
        .done        (done)
    );

    operand_feeder u_feeder
    (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .cnt      (cnt),
        .addr_a   (addr_a),
        .addr_b   (addr_b),
        .stride_a (stride_a),
        .stride_b (stride_b),
        .a_data   (a_data),
        .b_data   (b_data),
        .a_addr   (a_addr),
        .b_addr   (b_addr),
        .a_edge   (a_edge),
        .b_edge   (b_edge)
    );

    pe_array u_array
    (
        .clk     (clk),
        .clear   (array_clear),
        .a_edge  (a_edge),
        .b_edge  (b_edge),
        .results (results)
    );

    result_drain u_drain
    (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .latch    (latch),
        .addr_c   (addr_c),
        .stride_c (stride_c),
        .results  (results),
        .c_out    (c_out)
    );

endmodule

`default_nettype wire

// ==== hdl/matmul_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_sequencer
(
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    output systolic_pkg::cnt_t cnt,
    output logic               latch,
    output logic               array_clear,
    output logic               done
);

    import systolic_pkg::*;

    cnt_t cnt_q;
    logic done_q;

    ////////////////////////////////////////////////////////////
    // Cycle counter and done pulse
    ////////////////////////////////////////////////////////////

    // The count saturates so that a long start cannot raise done twice
    always_ff @(posedge clk)
    begin
        if (reset || !start)
        begin
            cnt_q  <= '0;
            done_q <= 1'b0;
        end
        else
        begin
            if (cnt_q != '1)
            begin
                cnt_q <= cnt_q + cnt_t'(1);
            end
            done_q <= (cnt_q == cnt_t'(DONE_CYCLE));
        end
    end

    assign cnt  = cnt_q;
    assign done = done_q;

    // Results are stable in the array on this count
    assign latch = (cnt_q == cnt_t'(LATCH_CYCLE));

    // Accumulators start from zero on every operation
    assign array_clear = reset || !start;

endmodule

`default_nettype wire

// ==== hdl/operand_feeder.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_feeder
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  systolic_pkg::cnt_t         cnt,
    input  systolic_pkg::addr_t        addr_a,
    input  systolic_pkg::addr_t        addr_b,
    input  systolic_pkg::stride_t      stride_a,
    input  systolic_pkg::stride_t      stride_b,
    input  systolic_pkg::operand_vec_t a_data,
    input  systolic_pkg::operand_vec_t b_data,
    output systolic_pkg::addr_t        a_addr,
    output systolic_pkg::addr_t        b_addr,
    output systolic_pkg::operand_vec_t a_edge,
    output systolic_pkg::operand_vec_t b_edge
);

    import systolic_pkg::*;

    // Side 0 feeds the A edge, side 1 the B edge
    wire addr_t        side_addr [2];
    wire operand_vec_t side_edge [2];

    // Addresses go out on the edges where cnt is 0 to N-1
    logic fetch;

    assign fetch = (cnt < cnt_t'(N));

    for (genvar s = 0; s < 2; s++)
    begin : g_side
        addr_t        base;
        stride_t      stride;
        operand_vec_t rdata;
        addr_t        addr_q;
        logic         access_q;
        cnt_t         access_cnt;
        logic         word_valid;
        operand_vec_t word;

        assign base   = (s == 0) ? addr_a : addr_b;
        assign stride = (s == 0) ? stride_a : stride_b;
        assign rdata  = (s == 0) ? a_data : b_data;

        ////////////////////////////////////////////////////////////
        // Address generation
        ////////////////////////////////////////////////////////////

        // The first fetch edge loads base, the later ones step by the stride
        always_ff @(posedge clk)
        begin
            if (reset || !start || !fetch)
            begin
                addr_q   <= base;
                access_q <= 1'b0;
            end
            else
            begin
                addr_q   <= (cnt == '0) ? base : addr_q + addr_t'(stride);
                access_q <= 1'b1;
            end
        end

        assign side_addr[s] = addr_q;

        // Counts issued reads; the word is valid once the memory latency has passed
        always_ff @(posedge clk)
        begin
            if (reset || !start || !access_q)
            begin
                access_cnt <= '0;
            end
            else
            begin
                access_cnt <= access_cnt + cnt_t'(1);
            end
        end

        assign word_valid = (access_cnt >= cnt_t'(MEM_LATENCY));
        assign word       = word_valid ? rdata : '0;

        ////////////////////////////////////////////////////////////
        // Diagonal skew
        ////////////////////////////////////////////////////////////

        assign side_edge[s][DATA_W-1:0] = word[DATA_W-1:0];

        // Lane i goes through i registers
        for (genvar i = 1; i < N; i++)
        begin : g_lane
            elem_t chain [i];

            always_ff @(posedge clk)
            begin
                if (reset || !start)
                begin
                    for (int d = 0; d < i; d++)
                    begin
                        chain[d] <= '0;
                    end
                end
                else
                begin
                    chain[0] <= word[i*DATA_W +: DATA_W];
                    for (int d = 1; d < i; d++)
                    begin
                        chain[d] <= chain[d-1];
                    end
                end
            end

            assign side_edge[s][i*DATA_W +: DATA_W] = chain[i-1];
        end
    end

    assign a_addr = side_addr[0];
    assign b_addr = side_addr[1];
    assign a_edge = side_edge[0];
    assign b_edge = side_edge[1];

endmodule

`default_nettype wire

// ==== hdl/pe_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module pe_array
(
    input  logic                       clk,
    input  logic                       clear,
    input  systolic_pkg::operand_vec_t a_edge,
    input  systolic_pkg::operand_vec_t b_edge,
    output systolic_pkg::result_mat_t  results
);

    import systolic_pkg::*;

    // a_link[i][j] enters PE(i,j) from the left, b_link[i][j] from the top
    elem_t a_link   [N][N+1];
    elem_t b_link   [N+1][N];
    elem_t acc_grid [N][N];

    ////////////////////////////////////////////////////////////
    // Mesh
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < N; i++)
    begin : g_row
        assign a_link[i][0] = a_edge[i*DATA_W +: DATA_W];
        assign b_link[0][i] = b_edge[i*DATA_W +: DATA_W];

        for (genvar j = 0; j < N; j++)
        begin : g_col
            mac_pe u_pe
            (
                .clk   (clk),
                .clear (clear),
                .in_a  (a_link[i][j]),
                .in_b  (b_link[i][j]),
                .out_a (a_link[i][j+1]),
                .out_b (b_link[i+1][j]),
                .acc   (acc_grid[i][j])
            );
        end
    end

    // Gather the accumulators column by column
    always_comb
    begin
        for (int j = 0; j < N; j++)
        begin
            for (int i = 0; i < N; i++)
            begin
                results[j][i*DATA_W +: DATA_W] = acc_grid[i][j];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/result_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_drain
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      latch,
    input  systolic_pkg::addr_t       addr_c,
    input  systolic_pkg::stride_t     stride_c,
    input  systolic_pkg::result_mat_t results,
    output systolic_pkg::c_write_t    c_out
);

    import systolic_pkg::*;

    logic         valid_q;
    cnt_t         beats_q;
    logic         shift;
    addr_t        addr_q;
    operand_vec_t data_q;
    operand_vec_t pend_q [N-1];

    // Moves the next column to the output while beats remain
    assign shift = valid_q && (beats_q != cnt_t'(N));

    ////////////////////////////////////////////////////////////
    // Beat control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !start)
        begin
            valid_q <= 1'b0;
            beats_q <= '0;
        end
        else if (latch)
        begin
            valid_q <= 1'b1;
            beats_q <= cnt_t'(1);
        end
        else if (shift)
        begin
            beats_q <= beats_q + cnt_t'(1);
        end
        else
        begin
            valid_q <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Column shift register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (latch)
        begin
            addr_q <= addr_c;
            data_q <= results[0];
            for (int k = 1; k < N; k++)
            begin
                pend_q[k-1] <= results[k];
            end
        end
        else if (shift)
        begin
            addr_q <= addr_q + addr_t'(stride_c);
            data_q <= pend_q[0];
            for (int k = 0; k < N - 2; k++)
            begin
                pend_q[k] <= pend_q[k+1];
            end
        end
    end

    assign c_out = '{valid: valid_q, addr: addr_q, data: data_q};

endmodule

`default_nettype wire

// ==== hdl/systolic_pkg.sv ====
`default_nettype none

package systolic_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int DATA_W   = 8;
    localparam int ADDR_W   = 10;
    localparam int STRIDE_W = 8;
    localparam int CNT_W    = 8;

    // Tile dimension, fixed for this array
    localparam int N = 4;

    ////////////////////////////////////////////////////////////
    // Schedule
    ////////////////////////////////////////////////////////////

    localparam int MAC_STAGES  = 3;
    localparam int MEM_LATENCY = 1;

    // Last accumulator update lands at 4N - N - 1 plus the MAC depth
    localparam int LATCH_CYCLE = 4 * N - N - 1 + MAC_STAGES;
    localparam int DONE_CYCLE  = 14 + MAC_STAGES;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic [DATA_W-1:0]   elem_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [STRIDE_W-1:0] stride_t;
    typedef logic [CNT_W-1:0]    cnt_t;

    // Element 0 sits in the low byte
    typedef logic [N*DATA_W-1:0] operand_vec_t;

    // Entry j holds column j of C, rows 0 to 3
    typedef operand_vec_t [N-1:0] result_mat_t;

    typedef struct packed {
        logic         valid;
        addr_t        addr;
        operand_vec_t data;
    } c_write_t;

endpackage

`default_nettype wire

// ==== test/matmul_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_sva
(
    input logic                   clk,
    input logic                   reset,
    input logic                   start,
    input logic                   done,
    input systolic_pkg::c_write_t c_out
);

    import systolic_pkg::*;

    logic       valid_d;
    logic [1:0] bursts;
    int         violations = 0;

    // Counts rising edges of c_out.valid within one operation
    always_ff @(posedge clk)
    begin
        if (reset || !start)
        begin
            valid_d <= 1'b0;
            bursts  <= '0;
        end
        else
        begin
            valid_d <= c_out.valid;
            if (c_out.valid && !valid_d && bursts != '1)
            begin
                bursts <= bursts + 2'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Protocol properties
    ////////////////////////////////////////////////////////////

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
    else
    begin
        violations++;
        $error("done stayed high for more than one cycle");
    end

    // A burst is exactly N beats long
    a_valid_burst: assert property (@(posedge clk) disable iff (reset)
        $rose(c_out.valid) |-> c_out.valid [*N] ##1 !c_out.valid)
    else
    begin
        violations++;
        $error("c_out.valid burst was not %0d cycles long", N);
    end

    a_one_burst: assert property (@(posedge clk) disable iff (reset)
        bursts <= 2'd1)
    else
    begin
        violations++;
        $error("more than one c_out burst in one operation");
    end

    a_reset_quiet: assert property (@(posedge clk)
        reset |=> !done && !c_out.valid)
    else
    begin
        violations++;
        $error("done or c_out.valid high after a reset cycle");
    end

endmodule

bind matmul_4x4_systolic matmul_sva u_sva
(
    .clk   (clk),
    .reset (reset),
    .start (start),
    .done  (done),
    .c_out (c_out)
);

`default_nettype wire

// ==== test/tb_matmul.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_matmul;

    import systolic_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int NUM_OPS      = 9;
    localparam int DONE_TIMEOUT = 60;
    localparam int MEM_WORDS    = 1 << ADDR_W;

    logic         clk;
    logic         reset;
    logic         start;
    addr_t        addr_a;
    addr_t        addr_b;
    addr_t        addr_c;
    stride_t      stride_a;
    stride_t      stride_b;
    stride_t      stride_c;
    addr_t        a_addr;
    addr_t        b_addr;
    operand_vec_t a_data;
    operand_vec_t b_data;
    c_write_t     c_out;
    logic         done;

    operand_vec_t mem_a [MEM_WORDS];
    operand_vec_t mem_b [MEM_WORDS];
    elem_t        mat_a [N][N];
    elem_t        mat_b [N][N];
    elem_t        exp_c [N][N];
    logic [31:0]  rng_state;
    int           op_cycle;
    int           first_beat_cycle;
    int           done_cycle;
    addr_t        a_seen [N];
    addr_t        b_seen [N];
    c_write_t     beats [$];

    matmul_4x4_systolic DUT
    (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .addr_a   (addr_a),
        .addr_b   (addr_b),
        .addr_c   (addr_c),
        .stride_a (stride_a),
        .stride_b (stride_b),
        .stride_c (stride_c),
        .a_addr   (a_addr),
        .b_addr   (b_addr),
        .a_data   (a_data),
        .b_data   (b_data),
        .c_out    (c_out),
        .done     (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // External memories with one cycle of read latency
    always @(posedge clk)
    begin
        a_data <= mem_a[a_addr];
        b_data <= mem_b[b_addr];
    end

    ////////////////////////////////////////////////////////////
    // Monitor: operation cycle, fetch addresses and C beats
    ////////////////////////////////////////////////////////////

    // op_cycle mirrors the schedule count seen at each edge
    always @(posedge clk)
    begin
        if (reset || !start)
        begin
            op_cycle <= 0;
        end
        else
        begin
            if (op_cycle >= 1 && op_cycle <= N)
            begin
                a_seen[op_cycle-1] <= a_addr;
                b_seen[op_cycle-1] <= b_addr;
            end
            op_cycle <= op_cycle + 1;
        end
        if (c_out.valid)
        begin
            if (beats.size() == 0)
            begin
                first_beat_cycle <= op_cycle;
            end
            beats.push_back(c_out);
        end
        if (done)
        begin
            done_cycle <= op_cycle;
        end
    end

    initial
    begin
        #((NUM_OPS * 40 + 60) * CLK_PERIOD);
        report_failure("Watchdog expired before the tests finished");
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic addr_t step_addr(input addr_t base, input stride_t stride, input int k);
        return addr_t'(int'(base) + k * int'(stride));
    endfunction

    task automatic next_elem(output elem_t value);
        rng_state = xorshift32(rng_state);
        value = rng_state[15:8];
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("Test FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < N; i++)
        begin
            for (int j = 0; j < N; j++)
            begin
                next_elem(mat_a[i][j]);
                next_elem(mat_b[i][j]);
            end
        end
    endtask

    // C[i][j] is the sum over k of A[i][k] * B[k][j], wrapped to 8 bits
    task automatic compute_reference();
        int acc;
        for (int i = 0; i < N; i++)
        begin
            for (int j = 0; j < N; j++)
            begin
                acc = 0;
                for (int k = 0; k < N; k++)
                begin
                    acc += int'(mat_a[i][k]) * int'(mat_b[k][j]);
                end
                exp_c[i][j] = elem_t'(acc % 256);
            end
        end
    endtask

    // Background depends on the full address, columns of A and rows of B go on top
    task automatic load_memories(input addr_t base_a, input stride_t sa,
                                 input addr_t base_b, input stride_t sb);
        operand_vec_t word_a;
        operand_vec_t word_b;
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            mem_a[a] = (32'(a) * 32'h9E37_79B9) ^ 32'h5A00_00C3;
            mem_b[a] = ~(32'(a) * 32'h85EB_CA6B);
        end
        for (int k = 0; k < N; k++)
        begin
            for (int i = 0; i < N; i++)
            begin
                word_a[i*DATA_W +: DATA_W] = mat_a[i][k];
                word_b[i*DATA_W +: DATA_W] = mat_b[k][i];
            end
            mem_a[step_addr(base_a, sa, k)] = word_a;
            mem_b[step_addr(base_b, sb, k)] = word_b;
        end
    endtask

    task automatic run_operation(input addr_t base_a, input stride_t sa,
                                 input addr_t base_b, input stride_t sb,
                                 input addr_t base_c, input stride_t sc);
        int waited;
        load_memories(base_a, sa, base_b, sb);
        beats.delete();
        first_beat_cycle = -1;
        done_cycle = -1;
        @(posedge clk);
        addr_a   <= base_a;
        addr_b   <= base_b;
        addr_c   <= base_c;
        stride_a <= sa;
        stride_b <= sb;
        stride_c <= sc;
        start    <= 1'b1;
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
        end
        while (!done && waited < DONE_TIMEOUT);
        if (!done)
        begin
            report_failure("done did not arrive within the timeout");
        end
        start <= 1'b0;
        // Idle cycle before the next start, and the last beat is collected
        @(posedge clk);
    endtask

    task automatic check_operation(input string tag);
        operand_vec_t expected;
        compute_reference();
        check_value({tag, " beat count"}, beats.size(), N);
        check_value({tag, " first c_out beat cycle"}, first_beat_cycle, LATCH_CYCLE + 1);
        check_value({tag, " done cycle"}, done_cycle, DONE_CYCLE + 1);
        check_value({tag, " sva violations"}, DUT.u_sva.violations, 0);
        for (int k = 0; k < N; k++)
        begin
            check_value($sformatf("%s a_addr %0d", tag, k), 32'(a_seen[k]),
                        32'(step_addr(addr_a, stride_a, k)));
            check_value($sformatf("%s b_addr %0d", tag, k), 32'(b_seen[k]),
                        32'(step_addr(addr_b, stride_b, k)));
        end
        for (int j = 0; j < N; j++)
        begin
            for (int i = 0; i < N; i++)
            begin
                expected[i*DATA_W +: DATA_W] = exp_c[i][j];
            end
            check_value($sformatf("%s c_out.addr beat %0d", tag, j), 32'(beats[j].addr),
                        32'(step_addr(addr_c, stride_c, j)));
            check_value($sformatf("%s c_out.data beat %0d", tag, j), beats[j].data, expected);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_identity();
        operand_vec_t column;
        fill_random();
        for (int i = 0; i < N; i++)
        begin
            for (int j = 0; j < N; j++)
            begin
                mat_a[i][j] = (i == j) ? 8'd1 : 8'd0;
            end
        end
        run_operation(10'h000, 8'd1, 10'h000, 8'd1, 10'h100, 8'd1);
        check_operation("identity");
        // Beat j must be column j of B
        for (int j = 0; j < N; j++)
        begin
            for (int i = 0; i < N; i++)
            begin
                column[i*DATA_W +: DATA_W] = mat_b[i][j];
            end
            check_value($sformatf("identity c_out.data beat %0d", j), beats[j].data, column);
        end
    endtask

    task automatic test_random();
        for (int r = 0; r < 3; r++)
        begin
            fill_random();
            run_operation(addr_t'(16 * r), 8'd1, addr_t'(64 + 4 * r), 8'd1,
                          addr_t'(512 + 8 * r), 8'd1);
            check_operation($sformatf("random %0d", r));
        end
    endtask

    // Bases near the top of memory make the address steps wrap
    task automatic test_strides();
        fill_random();
        run_operation(10'h3F0, 8'd7, 10'h155, 8'h13, 10'h3FE, 8'd3);
        check_operation("strides 0");
        fill_random();
        run_operation(10'd100, 8'd200, 10'd5, 8'hFF, 10'h200, 8'h40);
        check_operation("strides 1");
    endtask

    // A zero A after a full operation shows any sum left in the array
    task automatic test_back_to_back();
        fill_random();
        run_operation(10'h020, 8'd2, 10'h040, 8'd2, 10'h080, 8'd2);
        check_operation("back-to-back 0");
        fill_random();
        for (int i = 0; i < N; i++)
        begin
            for (int j = 0; j < N; j++)
            begin
                mat_a[i][j] = '0;
            end
        end
        run_operation(10'h020, 8'd2, 10'h040, 8'd2, 10'h080, 8'd2);
        check_operation("back-to-back 1");
        fill_random();
        run_operation(10'h030, 8'd5, 10'h050, 8'd9, 10'h0C0, 8'd1);
        check_operation("back-to-back 2");
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        addr_a = '0;
        addr_b = '0;
        addr_c = '0;
        stride_a = '0;
        stride_b = '0;
        stride_c = '0;
        a_data = '0;
        b_data = '0;
        rng_state = 32'd6804;
        first_beat_cycle = -1;
        done_cycle = -1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        test_identity();
        test_random();
        test_strides();
        test_back_to_back();

        // Properties that close after the last beat complete on this edge
        @(posedge clk);

        if (DUT.u_sva.violations == 0)
        begin
            $display("Test OK");
            $finish;
        end
        else
        begin
            report_failure("Protocol assertions failed after the last operation");
        end
    end

endmodule

`default_nettype wire
